// File: hw/fp_pkg.sv
// Float word format shared by the conversion unit
// Sign, biased exponent and a mantissa with a hidden leading one
package fp_pkg;

  // Exponent field width
  localparam int FP_EXP_BITS = 8;

  // Stored mantissa width, hidden one not included
  localparam int FP_MANT_BITS = 23;

  // Exponent bias, an exponent field of 127 means 2^0
  localparam int FP_EXP_OFFSET = 127;

  // Whole word: sign + exponent + mantissa
  localparam int FP_WORD_BITS = 1 + FP_EXP_BITS + FP_MANT_BITS;

  // Float word as it sits on the bus, sign in the top bit
  // An exponent field of zero stands for the value zero
  typedef struct packed {
    logic                    sign;
    logic [FP_EXP_BITS-1:0]  exp;
    logic [FP_MANT_BITS-1:0] mant;
  } fp_t;

endpackage

// File: hw/cvt_pkg.sv
// Conversion unit request and response formats
// Opcodes, result classes and the structs carried on both sides
package cvt_pkg;

  // Payload width of requests and responses, one float word
  localparam int CVT_DATA_BITS = 32;

  // Requested conversion
  typedef enum logic [0:0] {
    CVT_INT_TO_FP  = 1'b0,
    CVT_FP_TO_UINT = 1'b1
  } cvt_op_e;

  // Result class of a float to unsigned conversion
  // Integer to float results are always NORMAL
  typedef enum logic [1:0] {
    CLASS_NORMAL = 2'd0,
    CLASS_ZERO   = 2'd1,
    CLASS_SAT    = 2'd2
  } cvt_class_e;

  // Request word
  // Integer operands sit in the low INT_WIDTH bits of data
  // Float operands use all of data
  typedef struct packed {
    cvt_op_e                  op;
    logic [CVT_DATA_BITS-1:0] data;
  } cvt_req_t;

  // Response word
  // Float results carry the fp_t bits in data
  // Unsigned results are zero-extended to the full data width
  typedef struct packed {
    cvt_op_e                  op;
    cvt_class_e               cls;
    logic [CVT_DATA_BITS-1:0] data;
  } cvt_resp_t;

endpackage

// File: hw/clz.sv
// Leading-zero counter over a WIDTH-bit vector
// Purely combinational priority scan from the top bit down
module clz #(
  parameter int WIDTH = 32
) (
  input  logic [WIDTH-1:0]         x,
  output logic [$clog2(WIDTH)-1:0] count
);

  // Walk from the MSB, counting zeros until the first set bit
  // All-zero input gives a meaningless count, the caller checks for zero
  always_comb begin
    logic found;

    found = 1'b0;
    count = '0;
    for (int i = WIDTH - 1; i >= 0; i--) begin
      if (!found) begin
        // First one seen stops the count
        if (x[i]) begin
          found = 1'b1;
        end else begin
          count = count + 1'b1;
        end
      end
    end
  end

endmodule

// File: hw/int_to_fp.sv
// Signed integer to float encoder
// One register stage, mantissa truncated toward zero
module int_to_fp #(
  parameter int INT_WIDTH = 32
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [INT_WIDTH-1:0] n,
  output fp_pkg::fp_t          x
);
  import fp_pkg::*;

  // Width of the leading-zero count and of the MSB index
  localparam int CW = $clog2(INT_WIDTH);
  // Wide enough to hold the magnitude shifted up by a full mantissa
  localparam int WIDE = INT_WIDTH + FP_MANT_BITS;
  localparam int SH_BITS = $clog2(WIDE);

  logic                   sign;
  logic [INT_WIDTH-1:0]   mag;
  logic [CW-1:0]          lead_zeros;
  logic [CW-1:0]          msb_idx;
  logic [FP_EXP_BITS-1:0] exp_val;
  logic [WIDE-1:0]        mag_wide;
  logic [SH_BITS-1:0]     shr_amt;
  logic [SH_BITS-1:0]     shl_amt;
  logic [WIDE-1:0]        aligned;

  // Two's-complement magnitude
  // Most negative value maps to 100..0, still the right unsigned magnitude
  assign sign = n[INT_WIDTH-1];
  assign mag = sign ? (~n + 1'b1) : n;

  // Position of the leading one
  clz #(
    .WIDTH(INT_WIDTH)
  ) clz_inst (
    .x    (mag),
    .count(lead_zeros)
  );

  assign msb_idx = CW'(INT_WIDTH - 1) - lead_zeros;

  // Biased exponent
  assign exp_val = FP_EXP_BITS'(FP_EXP_OFFSET) + FP_EXP_BITS'(msb_idx);

  // Move the leading one to bit FP_MANT_BITS, so the bits below it
  // fill the stored mantissa; large values lose their low bits
  assign mag_wide = WIDE'(mag);
  assign shr_amt = SH_BITS'(msb_idx) - SH_BITS'(FP_MANT_BITS);
  assign shl_amt = SH_BITS'(FP_MANT_BITS) - SH_BITS'(msb_idx);
  assign aligned = (int'(msb_idx) >= FP_MANT_BITS) ? (mag_wide >> shr_amt)
                                                   : (mag_wide << shl_amt);

  // Output register, runs every cycle
  always_ff @(posedge clk) begin
    if (n == '0) begin
      // Zero has no leading one, encode as the all-zero word
      x <= '0;
    end else begin
      x.sign <= sign;
      x.exp  <= exp_val;
      x.mant <= aligned[FP_MANT_BITS-1:0];
    end
  end

  // Nonzero results come from a leading one somewhere in the integer,
  // so the exponent stays inside the integer's range
  a_exp_range: assert property (
    @(posedge clk) disable iff (rst)
    (x != '0) |->
      (x.exp >= FP_EXP_BITS'(FP_EXP_OFFSET)) &&
      (x.exp <= FP_EXP_BITS'(FP_EXP_OFFSET + INT_WIDTH - 1))
  ) else $error("int_to_fp exponent out of range");

endmodule

// File: hw/fp_to_uint.sv
// Float to fixed-point unsigned decoder
// Magnitude scaled by 2^FRAC, registered with its result class
module fp_to_uint #(
  parameter int INT_WIDTH = 32,
  parameter int FRAC = 0
) (
  input  logic                 clk,
  input  logic                 rst,
  input  fp_pkg::fp_t          x,
  output logic [INT_WIDTH-1:0] n,
  output cvt_pkg::cvt_class_e  cls
);
  import fp_pkg::*;
  import cvt_pkg::*;

  // One extra bit so exponent + FRAC cannot wrap
  localparam int EW = FP_EXP_BITS + 1;
  // Significand plus room to shift it up to the top integer bit
  localparam int WIDE = INT_WIDTH + FP_MANT_BITS + 1;

  localparam logic [EW-1:0] BIAS = EW'(FP_EXP_OFFSET);
  localparam logic [EW-1:0] MAX_EXP = EW'(FP_EXP_OFFSET + INT_WIDTH - 1);
  // Bit index of the hidden one inside the significand
  localparam logic [EW-1:0] LEAD_POS = EW'(FP_MANT_BITS);

  logic [EW-1:0]        exp_scaled;
  logic [EW-1:0]        pos;
  logic [WIDE-1:0]      sig_wide;
  logic [WIDE-1:0]      aligned;
  logic [INT_WIDTH-1:0] n_next;
  cvt_class_e           cls_next;

  // Scaling by 2^FRAC is an exponent offset
  assign exp_scaled = EW'(x.exp) + EW'(FRAC);

  // Target bit of the hidden one, only meaningful for NORMAL
  assign pos = exp_scaled - BIAS;

  // 1.mant with the hidden one restored
  assign sig_wide = WIDE'({1'b1, x.mant});

  // Left shift for big values, right shift drops fraction bits (floor)
  assign aligned = (pos >= LEAD_POS) ? (sig_wide << (pos - LEAD_POS))
                                     : (sig_wide >> (LEAD_POS - pos));

  // Classify and pick the value; sign bit is ignored
  always_comb begin
    if ((x.exp == '0) || (exp_scaled < BIAS)) begin
      // Zero encoding, or magnitude under one unit
      cls_next = CLASS_ZERO;
      n_next   = '0;
    end else if (exp_scaled > MAX_EXP) begin
      // Leading one would fall above the top bit
      cls_next = CLASS_SAT;
      n_next   = '1;
    end else begin
      cls_next = CLASS_NORMAL;
      n_next   = aligned[INT_WIDTH-1:0];
    end
  end

  // Output registers, no enable
  always_ff @(posedge clk) begin
    n   <= n_next;
    cls <= cls_next;
  end

  // NORMAL shift position lies inside the integer, and one cycle on
  // the registered value has its leading one exactly there
  a_normal_pos: assert property (
    @(posedge clk) disable iff (rst)
    (cls_next == CLASS_NORMAL) |->
      (pos < EW'(INT_WIDTH)) ##1 ((n >> $past(pos)) == INT_WIDTH'(1))
  ) else $error("fp_to_uint leading one misplaced");

endmodule

// File: hw/cvt_result_stage.sv
// Response stage of the conversion unit
// Tracks valid and opcode alongside the converters, then muxes and registers
module cvt_result_stage #(
  parameter int INT_WIDTH = 32
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 req_valid,
  input  cvt_pkg::cvt_op_e     op,
  input  fp_pkg::fp_t          fp_word,
  input  logic [INT_WIDTH-1:0] uint_value,
  input  cvt_pkg::cvt_class_e  uint_cls,
  output logic                 resp_valid,
  output cvt_pkg::cvt_resp_t   resp
);
  import cvt_pkg::*;

  // Request info delayed to line up with the converter registers
  logic      valid_q;
  cvt_op_e   op_q;
  cvt_resp_t resp_next;

  // Valid pipeline, the only state that needs reset
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q    <= 1'b0;
      resp_valid <= 1'b0;
    end else begin
      valid_q    <= req_valid;
      resp_valid <= valid_q;
    end
  end

  // Opcode follows the data, no reset
  always_ff @(posedge clk) begin
    op_q <= op;
  end

  // Pick the converter that matches the delayed opcode
  always_comb begin
    resp_next.op = op_q;
    if (op_q == CVT_INT_TO_FP) begin
      // Float results never saturate here
      resp_next.cls  = CLASS_NORMAL;
      resp_next.data = CVT_DATA_BITS'(fp_word);
    end else begin
      resp_next.cls  = uint_cls;
      // Zero-extend narrow integers
      resp_next.data = CVT_DATA_BITS'(uint_value);
    end
  end

  // Response register
  always_ff @(posedge clk) begin
    resp <= resp_next;
  end

  // A valid request always carries a known opcode
  a_op_known: assert property (
    @(posedge clk) disable iff (rst)
    req_valid |-> !$isunknown(op)
  ) else $error("opcode unknown on a valid request");

endmodule

// File: hw/fp_convert_unit.sv
// Integer and float conversion unit, top level
// Both converters see every request, the result stage picks one
module fp_convert_unit #(
  parameter int INT_WIDTH = 32,
  parameter int FRAC = 0
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               req_valid,
  input  cvt_pkg::cvt_req_t  req,
  output logic               resp_valid,
  output cvt_pkg::cvt_resp_t resp
);
  import fp_pkg::*;
  import cvt_pkg::*;

  // Converter outputs, one cycle after the request
  fp_t                  fp_word;
  logic [INT_WIDTH-1:0] uint_value;
  cvt_class_e           uint_cls;

  // Low bits of data read as a signed integer
  int_to_fp #(
    .INT_WIDTH(INT_WIDTH)
  ) int_to_fp_inst (
    .clk(clk),
    .rst(rst),
    .n  (req.data[INT_WIDTH-1:0]),
    .x  (fp_word)
  );

  // Whole data word read as a float
  fp_to_uint #(
    .INT_WIDTH(INT_WIDTH),
    .FRAC     (FRAC)
  ) fp_to_uint_inst (
    .clk(clk),
    .rst(rst),
    .x  (fp_t'(req.data)),
    .n  (uint_value),
    .cls(uint_cls)
  );

  // Valid and opcode delay, then response mux and register
  cvt_result_stage #(
    .INT_WIDTH(INT_WIDTH)
  ) cvt_result_stage_inst (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .op        (req.op),
    .fp_word   (fp_word),
    .uint_value(uint_value),
    .uint_cls  (uint_cls),
    .resp_valid(resp_valid),
    .resp      (resp)
  );

endmodule

// File: bench/fp_convert_unit_tb.sv
// Testbench for the integer and float conversion unit
// Random requests from a fixed seed, checked against a behavioral model
module fp_convert_unit_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import fp_pkg::*;
  import cvt_pkg::*;

  localparam int INT_W = 32;
  localparam int FRAC_BITS = 4;
  // Longest wait for outstanding responses
  localparam int DRAIN_LIMIT = 50;

  logic      clk;
  logic      rst;
  logic      req_valid;
  cvt_req_t  req;
  logic      resp_valid;
  cvt_resp_t resp;

  // Expected responses in request order, with issue cycle and test name
  cvt_resp_t exp_q[$];
  int        cyc_q[$];
  string     name_q[$];
  int        cycle;
  int        sent;
  int        checked;

  fp_convert_unit #(
    .INT_WIDTH(INT_W),
    .FRAC     (FRAC_BITS)
  ) fp_convert_unit_inst (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req       (req),
    .resp_valid(resp_valid),
    .resp      (resp)
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Cycle count used for the latency check
  initial cycle = 0;
  always @(posedge clk) cycle++;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "simulation stopped on error");
  endtask

  // Sign, top-bit index plus bias, bits under the top bit left-aligned
  function automatic fp_t model_int_to_fp(input logic [INT_W-1:0] v);
    fp_t              w;
    logic [INT_W-1:0] mag;
    int               top;
    int               src;
    w = '0;
    top = 0;
    if (v != '0) begin
      mag = v[INT_W-1] ? (INT_W'(0) - v) : v;
      for (int i = 0; i < INT_W; i++) begin
        if (mag[i]) top = i;
      end
      w.sign = v[INT_W-1];
      w.exp  = FP_EXP_BITS'(FP_EXP_OFFSET + top);
      // Walk down from just below the top bit, truncating the rest
      for (int k = 0; k < FP_MANT_BITS; k++) begin
        src = top - 1 - k;
        if (src >= 0) w.mant[FP_MANT_BITS-1-k] = mag[src];
      end
    end
    return w;
  endfunction

  // floor(1.mant * 2^(exp + FRAC - 127)), magnitude only
  task automatic model_fp_to_uint(input fp_t f, output logic [INT_W-1:0] val,
                                  output cvt_class_e cls);
    logic [FP_MANT_BITS:0] sig;
    int                    e;
    int                    idx;
    sig = {1'b1, f.mant};
    e = int'(f.exp) + FRAC_BITS - FP_EXP_OFFSET;
    val = '0;
    if ((f.exp == '0) || (e < 0)) begin
      cls = CLASS_ZERO;
    end else if (e > INT_W - 1) begin
      cls = CLASS_SAT;
      val = '1;
    end else begin
      cls = CLASS_NORMAL;
      // Result bit j takes the significand bit that lands on it
      for (int j = 0; j < INT_W; j++) begin
        idx = j + FP_MANT_BITS - e;
        if ((idx >= 0) && (idx <= FP_MANT_BITS)) val[j] = sig[idx];
      end
    end
  endtask

  task automatic compare_fp(input string name, input fp_t exp_w, input fp_t act_w,
                            input cvt_class_e act_cls);
    cvt_class_e normal_cls;
    normal_cls = CLASS_NORMAL;
    if (act_w !== exp_w) begin
      abort_run($sformatf("FAILED %s: float word expected %h actual %h",
                          name, exp_w, act_w));
    end else if (act_cls !== normal_cls) begin
      abort_run($sformatf("FAILED %s: class expected %s actual %s",
                          name, normal_cls.name(), act_cls.name()));
    end
  endtask

  task automatic compare_uint(input string name, input logic [INT_W-1:0] exp_v,
                              input cvt_class_e exp_c, input logic [INT_W-1:0] act_v,
                              input cvt_class_e act_c);
    if (act_c !== exp_c) begin
      abort_run($sformatf("FAILED %s: class expected %s actual %s",
                          name, exp_c.name(), act_c.name()));
    end else if (act_v !== exp_v) begin
      abort_run($sformatf("FAILED %s: value expected %h actual %h", name, exp_v, act_v));
    end
  endtask

  task automatic compare_op(input string name, input cvt_op_e exp_op, input cvt_op_e act_op);
    if (act_op !== exp_op) begin
      abort_run($sformatf("FAILED %s: opcode expected %s actual %s",
                          name, exp_op.name(), act_op.name()));
    end
  endtask

  // Drive one request for one cycle and queue its expected response
  task automatic issue_request(input cvt_op_e op, input logic [31:0] data, input string name);
    cvt_resp_t        exp_r;
    logic [INT_W-1:0] v;
    cvt_class_e       c;
    @(posedge clk);
    #1;
    req_valid = 1'b1;
    req.op    = op;
    req.data  = data;
    exp_r.op  = op;
    if (op == CVT_INT_TO_FP) begin
      exp_r.cls  = CLASS_NORMAL;
      exp_r.data = model_int_to_fp(data[INT_W-1:0]);
    end else begin
      model_fp_to_uint(fp_t'(data), v, c);
      exp_r.cls  = c;
      exp_r.data = CVT_DATA_BITS'(v);
    end
    exp_q.push_back(exp_r);
    cyc_q.push_back(cycle);
    name_q.push_back(name);
    sent++;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
      req_valid = 1'b0;
    end
  endtask

  task automatic wait_for_drain();
    int waited;
    waited = 0;
    while ((exp_q.size() != 0) && (waited < DRAIN_LIMIT)) begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() != 0) abort_run("Timed out waiting for outstanding responses");
  endtask

  task automatic check_response();
    cvt_resp_t exp_r;
    int        exp_cycle;
    string     name;
    if (exp_q.size() == 0) begin
      abort_run("Response arrived with no request outstanding");
    end else begin
      exp_r = exp_q.pop_front();
      exp_cycle = cyc_q.pop_front() + 2;
      name = name_q.pop_front();
      if (cycle != exp_cycle) begin
        abort_run($sformatf("FAILED %s: response cycle expected %0d actual %0d",
                            name, exp_cycle, cycle));
      end
      compare_op(name, exp_r.op, resp.op);
      if (exp_r.op == CVT_INT_TO_FP) begin
        compare_fp(name, fp_t'(exp_r.data), fp_t'(resp.data), resp.cls);
      end else begin
        compare_uint(name, exp_r.data[INT_W-1:0], exp_r.cls,
                     resp.data[INT_W-1:0], resp.cls);
      end
      checked++;
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (cycle > 0) begin
      if ($isunknown(resp_valid)) abort_run("resp_valid is unknown");
      else if (rst && resp_valid) abort_run("resp_valid went high during reset");
      else if (resp_valid) check_response();
    end
  end

  initial begin
    void'($urandom(42));
    rst = 1'b1;
    // Strobes held high through reset must all be dropped
    req_valid = 1'b1;
    req = '0;
    sent = 0;
    checked = 0;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    req_valid = 1'b0;
    // Quiet cycles after reset, any response here is flagged
    idle_cycles(4);

    // Random signed integers
    repeat (200) begin
      issue_request(CVT_INT_TO_FP, $urandom, "int_random");
      if ($urandom % 3 == 0) idle_cycles(1);
    end
    // Integer edge cases
    issue_request(CVT_INT_TO_FP, 32'h0000_0000, "int_zero");
    issue_request(CVT_INT_TO_FP, 32'h0000_0001, "int_one");
    issue_request(CVT_INT_TO_FP, 32'hFFFF_FFFF, "int_minus_one");
    issue_request(CVT_INT_TO_FP, 32'h8000_0000, "int_most_negative");
    issue_request(CVT_INT_TO_FP, 32'h7FFF_FFFF, "int_most_positive");
    idle_cycles(2);
    wait_for_drain();

    // In-range floats, scaled exponent from 0 to INT_W-1
    repeat (200) begin
      issue_request(CVT_FP_TO_UINT,
                    {1'($urandom), 8'(123 + $urandom % 32), 23'($urandom)}, "uint_in_range");
    end
    // Underflow to zero, including the zero exponent
    issue_request(CVT_FP_TO_UINT, {1'($urandom), 8'd0, 23'($urandom)}, "uint_zero_exp");
    repeat (50) begin
      issue_request(CVT_FP_TO_UINT,
                    {1'($urandom), 8'(1 + $urandom % 122), 23'($urandom)}, "uint_underflow");
    end
    // Saturation above the top integer bit
    repeat (50) begin
      issue_request(CVT_FP_TO_UINT,
                    {1'($urandom), 8'(155 + $urandom % 101), 23'($urandom)}, "uint_saturate");
    end
    idle_cycles(2);
    wait_for_drain();

    // Mixed stream, back to back with random gaps
    repeat (400) begin
      issue_request(cvt_op_e'($urandom % 2), $urandom, "mixed_stream");
      if ($urandom % 4 == 0) idle_cycles(1 + $urandom % 3);
    end
    idle_cycles(2);
    wait_for_drain();

    if ((checked == sent) && (sent > 0)) begin
      $display("Regression passed");
      $finish;
    end else begin
      abort_run($sformatf("Response count mismatch: %0d sent, %0d checked", sent, checked));
    end
  end

endmodule

// File: fp_convert_unit.f
hw/fp_pkg.sv
hw/cvt_pkg.sv
hw/clz.sv
hw/int_to_fp.sv
hw/fp_to_uint.sv
hw/cvt_result_stage.sv
hw/fp_convert_unit.sv
bench/fp_convert_unit_tb.sv

// File: Makefile
# Verilator build and run for the conversion unit testbench

VERILATOR ?= verilator
TOP       ?= fp_convert_unit_tb
BUILD_DIR ?= build
FILELIST  ?= fp_convert_unit.f
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) \
		-o V$(TOP) -f $(FILELIST)

# Exit status of the simulation is the pass or fail result
run: $(SIM_BIN)
	./$(SIM_BIN)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
